// ==== design/router_fifo.sv ====
`timescale 1ns/1ps

module router_fifo
    import router_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  soft_reset,
    input  logic  write_enb,
    input  byte_t data_in,
    input  logic  read_enb,
    output byte_t data_out,
    output logic  full,
    output logic  empty
);

    byte_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    // full writes are dropped here too, controller never issues them
    assign push = write_enb && !full;
    assign pop  = read_enb && !empty;

    // first word fall through
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst || soft_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/router_fsm.sv ====
`timescale 1ns/1ps

module router_fsm
    import router_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  pkt_valid,
    input  addr_t addr,
    input  logic  fifo_full,
    input  logic  last_byte,
    output logic  busy,
    output logic  detect_addr,
    output logic  lfd_state,
    output logic  ld_state,
    output logic  write_enb_reg,
    output logic  parity_check
);

    state_t state;
    state_t next_state;
    logic   to_port;
    logic   ld_take;

    // port 3 packets run the same sequence without writing
    assign to_port = (addr != 2'd3);

    assign detect_addr  = (state == decode_address) && pkt_valid;
    assign lfd_state    = (state == load_first);
    assign ld_state     = (state == load_data);
    assign parity_check = (state == check_parity);

    // payload or parity byte taken this cycle
    assign ld_take = ld_state && pkt_valid && !fifo_full;

    assign write_enb_reg = to_port && ((lfd_state && !fifo_full) || ld_take);

    assign busy = lfd_state || parity_check || (state == fifo_wait) ||
                  (ld_state && fifo_full);

    always_comb begin
        next_state = state;
        case (state)
            decode_address: begin
                if (pkt_valid) begin
                    next_state = load_first;
                end
            end
            load_first: begin
                // header waits here if the port is still full
                if (!fifo_full) begin
                    next_state = load_data;
                end
            end
            load_data: begin
                if (fifo_full) begin
                    next_state = fifo_wait;
                end else if (pkt_valid && last_byte) begin
                    next_state = check_parity;
                end
            end
            fifo_wait: begin
                if (!fifo_full) begin
                    next_state = load_data;
                end
            end
            check_parity: begin
                next_state = decode_address;
            end
            default: begin
                next_state = decode_address;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= decode_address;
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== design/router_pkg.sv ====
package router_pkg;

    // stream and header fields
    typedef logic [7:0] byte_t;
    typedef logic [1:0] addr_t;
    typedef logic [5:0] len_t;

    // output fifo geometry
    localparam int FIFO_DEPTH = 16;
    localparam int PTR_W = 4;

    // unread cycles before a port is flushed
    localparam int TIMEOUT_CYCLES = 30;

    typedef enum logic [2:0] {
        decode_address,
        load_first,
        load_data,
        fifo_wait,
        check_parity
    } state_t;

endpackage

// ==== design/router_reg.sv ====
`timescale 1ns/1ps

module router_reg
    import router_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t data_in,
    input  logic  pkt_valid,
    input  logic  busy,
    input  logic  detect_addr,
    input  logic  lfd_state,
    input  logic  ld_state,
    input  logic  parity_check,
    output byte_t dout,
    output addr_t addr,
    output logic  last_byte,
    output logic  err
);

    byte_t header;
    byte_t int_parity;
    byte_t pkt_parity;
    len_t  remaining;
    logic  ld_accept;

    assign ld_accept = ld_state && pkt_valid && !busy;
    assign last_byte = (remaining == '0);

    // header goes out one cycle after it was taken
    assign dout = lfd_state ? header : data_in;
    assign addr = detect_addr ? data_in[1:0] : header[1:0];

    always_ff @(posedge clk) begin
        if (detect_addr) begin
            header     <= data_in;
            int_parity <= data_in;
        end else if (ld_accept && !last_byte) begin
            int_parity <= int_parity ^ data_in;
        end
        if (ld_accept && last_byte) begin
            pkt_parity <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            remaining <= '0;
            err       <= 1'b0;
        end else begin
            if (lfd_state) begin
                remaining <= header[7:2];
            end else if (ld_accept && !last_byte) begin
                remaining <= remaining - 1'b1;
            end
            if (detect_addr) begin
                err <= 1'b0;
            end else if (parity_check) begin
                err <= (int_parity != pkt_parity);
            end
        end
    end

endmodule

// ==== design/router_sync.sv ====
`timescale 1ns/1ps

module router_sync
    import router_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  addr_t      addr,
    input  logic       detect_addr,
    input  logic       write_enb_reg,
    input  logic       full_0,
    input  logic       full_1,
    input  logic       full_2,
    input  logic       empty_0,
    input  logic       empty_1,
    input  logic       empty_2,
    input  logic       read_enb_0,
    input  logic       read_enb_1,
    input  logic       read_enb_2,
    output logic [2:0] wr_en,
    output logic       fifo_full,
    output logic       vld_out_0,
    output logic       vld_out_1,
    output logic       vld_out_2,
    output logic       soft_reset_0,
    output logic       soft_reset_1,
    output logic       soft_reset_2
);

    addr_t      dest;
    logic [2:0] vld_vec;
    logic [2:0] rd_vec;

    always_ff @(posedge clk) begin
        if (!rst) begin
            dest <= '0;
        end else if (detect_addr) begin
            dest <= addr;
        end
    end

    // write steering and full select, port 3 goes nowhere
    always_comb begin
        case (dest)
            2'd0:    begin fifo_full = full_0; wr_en = {2'b00, write_enb_reg}; end
            2'd1:    begin fifo_full = full_1; wr_en = {1'b0, write_enb_reg, 1'b0}; end
            2'd2:    begin fifo_full = full_2; wr_en = {write_enb_reg, 2'b00}; end
            default: begin fifo_full = 1'b0;   wr_en = 3'b000; end
        endcase
    end

    assign vld_out_0 = !empty_0;
    assign vld_out_1 = !empty_1;
    assign vld_out_2 = !empty_2;

    assign vld_vec = {vld_out_2, vld_out_1, vld_out_0};
    assign rd_vec  = {read_enb_2, read_enb_1, read_enb_0};

    for (genvar k = 0; k < 3; k++) begin : g_timer
        logic [$clog2(TIMEOUT_CYCLES)-1:0] idle_cnt;
        logic                              soft_q;
        logic                              idle;
        logic                              expired;

        assign idle    = vld_vec[k] && !rd_vec[k];
        assign expired = (idle_cnt == TIMEOUT_CYCLES - 1);

        always_ff @(posedge clk) begin
            if (!rst) begin
                idle_cnt <= '0;
                soft_q   <= 1'b0;
            end else begin
                soft_q <= idle && expired;
                // hold at zero through the flush cycle
                if (!idle || soft_q || expired) begin
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    assign soft_reset_0 = g_timer[0].soft_q;
    assign soft_reset_1 = g_timer[1].soft_q;
    assign soft_reset_2 = g_timer[2].soft_q;

endmodule

// ==== design/router_top.sv ====
`timescale 1ns/1ps

module router_top
    import router_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t data_in,
    input  logic  pkt_valid,
    output logic  busy,
    output logic  err,
    output byte_t data_out_0,
    output byte_t data_out_1,
    output byte_t data_out_2,
    output logic  vld_out_0,
    output logic  vld_out_1,
    output logic  vld_out_2,
    input  logic  read_enb_0,
    input  logic  read_enb_1,
    input  logic  read_enb_2
);

    logic       detect_addr;
    logic       lfd_state;
    logic       ld_state;
    logic       write_enb_reg;
    logic       parity_check;
    logic       last_byte;
    logic       fifo_full;
    byte_t      dout;
    addr_t      addr;
    logic [2:0] wr_en;
    logic       full_0, full_1, full_2;
    logic       empty_0, empty_1, empty_2;
    logic       soft_reset_0, soft_reset_1, soft_reset_2;

    router_fsm u_fsm (
        .clk, .rst, .pkt_valid, .addr, .fifo_full, .last_byte,
        .busy, .detect_addr, .lfd_state, .ld_state, .write_enb_reg, .parity_check
    );

    router_reg u_reg (
        .clk, .rst, .data_in, .pkt_valid, .busy, .detect_addr, .lfd_state,
        .ld_state, .parity_check, .dout, .addr, .last_byte, .err
    );

    router_sync u_sync (
        .clk, .rst, .addr, .detect_addr, .write_enb_reg,
        .full_0, .full_1, .full_2, .empty_0, .empty_1, .empty_2,
        .read_enb_0, .read_enb_1, .read_enb_2, .wr_en, .fifo_full,
        .vld_out_0, .vld_out_1, .vld_out_2,
        .soft_reset_0, .soft_reset_1, .soft_reset_2
    );

    router_fifo u_fifo_0 (
        .clk, .rst, .soft_reset(soft_reset_0), .write_enb(wr_en[0]), .data_in(dout),
        .read_enb(read_enb_0), .data_out(data_out_0), .full(full_0), .empty(empty_0)
    );

    router_fifo u_fifo_1 (
        .clk, .rst, .soft_reset(soft_reset_1), .write_enb(wr_en[1]), .data_in(dout),
        .read_enb(read_enb_1), .data_out(data_out_1), .full(full_1), .empty(empty_1)
    );

    router_fifo u_fifo_2 (
        .clk, .rst, .soft_reset(soft_reset_2), .write_enb(wr_en[2]), .data_in(dout),
        .read_enb(read_enb_2), .data_out(data_out_2), .full(full_2), .empty(empty_2)
    );

endmodule

// ==== dv/router_properties.sv ====
`timescale 1ns/1ps

module router_properties (
    input logic       clk,
    input logic       rst,
    input logic [2:0] wr_en,
    input logic       full_0,
    input logic       full_1,
    input logic       full_2,
    input logic       soft_reset_0,
    input logic       soft_reset_1,
    input logic       soft_reset_2
);

    // at most one port written per cycle
    a_wr_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot0(wr_en))
        else $error("wr_en is not one-hot or zero: %b", wr_en);

    // each fifo's own full flag, not the selected copy
    a_no_full_write: assert property (@(posedge clk) disable iff (!rst)
        !((wr_en[0] && full_0) || (wr_en[1] && full_1) || (wr_en[2] && full_2)))
        else $error("write issued while the selected fifo is full");

    // flush pulses are single cycle
    a_soft_0: assert property (@(posedge clk) disable iff (!rst) soft_reset_0 |=> !soft_reset_0)
        else $error("soft_reset_0 held longer than one cycle");
    a_soft_1: assert property (@(posedge clk) disable iff (!rst) soft_reset_1 |=> !soft_reset_1)
        else $error("soft_reset_1 held longer than one cycle");
    a_soft_2: assert property (@(posedge clk) disable iff (!rst) soft_reset_2 |=> !soft_reset_2)
        else $error("soft_reset_2 held longer than one cycle");

endmodule

bind router_top router_properties u_props (
    .clk(clk), .rst(rst), .wr_en(wr_en),
    .full_0(full_0), .full_1(full_1), .full_2(full_2),
    .soft_reset_0(soft_reset_0), .soft_reset_1(soft_reset_1), .soft_reset_2(soft_reset_2)
);

// ==== dv/router_tb.sv ====
`timescale 1ns/1ps

module router_tb
    import router_pkg::*;
;

    localparam int NUM_PKTS   = 40;
    localparam int MAX_CYCLES = NUM_PKTS * (20 + 4) * 4 + 2000;

    logic       clk;
    logic       rst;
    byte_t      data_in;
    logic       pkt_valid;
    logic       busy;
    logic       err;
    byte_t      data_out [3];
    logic [2:0] vld_out;
    logic [2:0] read_enb;

    integer     seed = 91;
    int         cycles = 0;
    int         data_errs = 0;
    int         flag_errs = 0;
    int         misc_errs = 0;
    int         stalls = 0;
    byte_t      model_q [3][$];
    int         idle_cnt [3] = '{0, 0, 0};
    int         hold_left [3] = '{0, 0, 0};
    logic [2:0] flush_now = '0;

    router_top u_dut (
        .clk, .rst, .data_in, .pkt_valid, .busy, .err,
        .data_out_0(data_out[0]), .data_out_1(data_out[1]), .data_out_2(data_out[2]),
        .vld_out_0(vld_out[0]), .vld_out_1(vld_out[1]), .vld_out_2(vld_out[2]),
        .read_enb_0(read_enb[0]), .read_enb_1(read_enb[1]), .read_enb_2(read_enb[2])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // one cycle of readers, output checks and the idle timer mirror
    task automatic tick();
        logic idle;
        logic expired;
        @(negedge clk);
        for (int k = 0; k < 3; k++) begin
            read_enb[k] = (hold_left[k] == 0) && (($random(seed) & 1) == 1);
            if (hold_left[k] > 0) begin
                hold_left[k]--;
            end
            if (vld_out[k] && model_q[k].size() == 0) begin
                $display("vld_out_%0d is high but no byte is expected on that port", k);
                misc_errs++;
            end else if (flush_now[k]) begin
                model_q[k].delete();
            end else if (vld_out[k] && read_enb[k]) begin
                if (data_out[k] != model_q[k][0]) begin
                    $display("Fail data_out_%0d expected %h actual %h",
                             k, model_q[k][0], data_out[k]);
                    data_errs++;
                end
                void'(model_q[k].pop_front());
            end
            // 30th idle cycle in a row flushes on the next one
            idle = vld_out[k] && !read_enb[k];
            expired = (idle_cnt[k] == TIMEOUT_CYCLES - 1);
            idle_cnt[k] = (!idle || flush_now[k] || expired) ? 0 : idle_cnt[k] + 1;
            flush_now[k] = idle && expired;
        end
    endtask

    task automatic send_packet(input addr_t dst, input len_t len, input logic bad);
        byte_t pkt [$];
        byte_t par;
        int    i;
        pkt.push_back({len, dst});
        par = {len, dst};
        for (i = 0; i < len; i++) begin
            pkt.push_back(byte_t'($random(seed)));
            par ^= pkt[i + 1];
        end
        pkt.push_back(bad ? (par ^ 8'h5a) : par);
        i = 0;
        while (i < pkt.size()) begin
            tick();
            data_in = pkt[i];
            pkt_valid = 1'b1;
            // busy is registered, so its value now holds at the next edge
            if (!busy) begin
                if (dst != 2'd3) begin
                    model_q[dst].push_back(pkt[i]);
                end
                i++;
            end else if (i > 0) begin
                stalls++;
            end
        end
        tick();
        pkt_valid = 1'b0;
        while (busy) begin
            tick();
        end
        if (err != bad) begin
            $display("Fail err expected %h actual %h", bad, err);
            flag_errs++;
        end
    endtask

    task automatic drain();
        while (vld_out != 3'b000 ||
               model_q[0].size() + model_q[1].size() + model_q[2].size() != 0) begin
            tick();
        end
    endtask

    initial begin
        addr_t dst;
        len_t  len;
        logic  bad;
        rst = 1'b0;
        data_in = '0;
        pkt_valid = 1'b0;
        read_enb = '0;
        repeat (16) tick();
        if (busy || err || vld_out != 3'b000) begin
            $display("busy, err or a vld_out is not low during reset");
            misc_errs++;
        end
        rst = 1'b1;
        for (int p = 0; p < NUM_PKTS; p++) begin
            dst = addr_t'($random(seed));
            len = len_t'(1 + {$random(seed)} % 20);
            bad = (($random(seed) & 3) == 0);
            send_packet(dst, len, bad);
        end
        drain();
        // port 1 stalls long enough to fill, reads resume before the timeout
        hold_left[1] = 28;
        stalls = 0;
        send_packet(2'd1, 6'd20, 1'b0);
        if (stalls < 3) begin
            $display("source never saw back-pressure from port 1");
            misc_errs++;
        end
        drain();
        // port 2 is never read, so it has to flush itself
        hold_left[2] = 1000;
        send_packet(2'd2, 6'd10, 1'b0);
        repeat (40) tick();
        if (vld_out[2] || model_q[2].size() != 0) begin
            $display("port 2 still holds data after 40 unread cycles");
            misc_errs++;
        end
        hold_left[2] = 0;
        for (int p = 0; p < 3; p++) begin
            send_packet(2'd2, len_t'(1 + {$random(seed)} % 20), 1'b0);
        end
        drain();
        $display("errors: data %0d, err flag %0d, other %0d", data_errs, flag_errs, misc_errs);
        if (data_errs + flag_errs + misc_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the router testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -sv -Wno-fatal -f sources.f \
    --top-module router_tb -o router_sim > build.log 2>&1 \
    && ./obj_dir/router_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// ==== sources.f ====
design/router_pkg.sv
design/router_fifo.sv
design/router_sync.sv
design/router_fsm.sv
design/router_reg.sv
design/router_top.sv
dv/router_properties.sv
dv/router_tb.sv
